// File: hdl/pc_types_pkg.sv
`default_nettype none

// Address and instruction size types shared by the fetch, buffer and checker
package pc_types_pkg;

  // One instruction address, a full 32-bit word
  typedef logic [31:0] pc_t;

  // Size flag of the instruction at a given address
  // High means a 16-bit compressed instruction
  typedef logic instr_size_t;

  // Step for a compressed instruction
  localparam pc_t PC_INCR_CMPR = 32'd2;

  // Step for a full 32-bit instruction
  localparam pc_t PC_INCR_FULL = 32'd4;

  // Sequential successor of an address
  function automatic pc_t pc_incr(pc_t pc, instr_size_t cmpr);
    pc_t step;
    step = cmpr ? PC_INCR_CMPR : PC_INCR_FULL;
    return pc + step;
  endfunction

endpackage

`default_nettype wire

// File: hdl/pc_ctrl_pkg.sv
`default_nettype none

// Control-flow encodings and checker state for the hardened PC
package pc_ctrl_pkg;

  // Cause of a non-sequential PC
  // Only kept so an alert can report which kind of target was wrong
  typedef enum logic [1:0] {
    REDIR_BRANCH = 2'd0,
    REDIR_JUMP   = 2'd1,
    REDIR_MRET   = 2'd2
  } redirect_kind_e;

  // What the checker expects for the next accepted address
  typedef enum logic [1:0] {
    // First address after reset must be the boot address
    CHK_INIT  = 2'd0,
    // Previous accepted address plus its instruction size
    CHK_SEQ   = 2'd1,
    // Duplicate target captured at the last redirect
    CHK_REDIR = 2'd2
  } chk_state_e;

endpackage

`default_nettype wire

// File: hdl/fetch_pc_gen.sv
`default_nettype none
`timescale 1ns/10ps

// Fetch side PC producer
// Holds the current fetch address and offers it on a valid/ready handshake
module fetch_pc_gen
  import pc_types_pkg::*;
#(
  parameter pc_t BOOT_ADDR = 32'h0000_0080
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  // Size of the instruction sitting at the current fetch PC
  input  wire instr_size_t is_compressed_i,
  // Control-flow change from branch, jump or return
  input  wire logic        redirect_valid_i,
  input  wire pc_t         redirect_target_i,
  // Glitch injection hook on the PC register
  input  wire pc_t         fault_pc_mask_i,
  // Downstream handshake
  input  wire logic        if_ready_i,
  output logic             if_valid_o,
  output pc_t              if_pc_o,
  output instr_size_t      if_cmpr_o
);

  // Fetch PC register
  pc_t  pc_q;

  // Next PC before the fault mask
  pc_t  pc_sel;

  // Next PC as written into the register
  pc_t  pc_d;

  // Offer flag, low only while in reset
  logic valid_q;

  // Address handed to the buffer this cycle
  logic xfer;

  assign xfer = valid_q && if_ready_i;

  // Next PC selection
  // Redirect wins over a transfer and drops the address on offer
  always_comb begin
    if (redirect_valid_i) begin
      pc_sel = redirect_target_i;
    end else if (xfer) begin
      // Step over the instruction that was just handed on
      pc_sel = pc_incr(pc_q, is_compressed_i);
    end else begin
      // Back-pressure or not yet valid, keep the address
      pc_sel = pc_q;
    end
  end

  // Fault mask flips bits on top of whatever was chosen
  // A zero mask leaves the value unchanged
  assign pc_d = pc_sel ^ fault_pc_mask_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q    <= BOOT_ADDR;
      valid_q <= 1'b0;
    end else begin
      pc_q    <= pc_d;
      // Starts offering on the first edge after reset and never stops
      valid_q <= 1'b1;
    end
  end

  // Handshake outputs
  assign if_valid_o = valid_q;
  assign if_pc_o    = pc_q;

  // Size flag belongs to the address on offer
  assign if_cmpr_o  = is_compressed_i;

endmodule

`default_nettype wire

// File: hdl/if_id_buffer.sv
`default_nettype none
`timescale 1ns/10ps

// Two-entry FIFO between fetch and decode
// Stores each address with its size flag and is emptied by a redirect
module if_id_buffer
  import pc_types_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  // Redirect flush, drops all held entries
  input  wire logic        flush_i,
  // Write side from fetch
  input  wire logic        if_valid_i,
  input  wire pc_t         if_pc_i,
  input  wire instr_size_t if_cmpr_i,
  output logic             if_ready_o,
  // Read side toward the checker
  output logic             buf_valid_o,
  output pc_t              buf_pc_o,
  output instr_size_t      buf_cmpr_o,
  input  wire logic        buf_ready_i
);

  localparam int DEPTH = 2;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // Entry storage
  pc_t         mem_pc   [DEPTH];
  instr_size_t mem_cmpr [DEPTH];

  // Pointers wrap naturally since the depth is a power of two
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;

  // Number of held entries
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;

  // Full when every entry is taken
  assign if_ready_o  = (count_q != CNT_W'(DEPTH));
  assign buf_valid_o = (count_q != '0);

  assign push = if_valid_i && if_ready_o;
  assign pop  = buf_valid_o && buf_ready_i;

  // Oldest entry is always on the output
  assign buf_pc_o   = mem_pc[rd_ptr_q];
  assign buf_cmpr_o = mem_cmpr[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Anything pushed on this edge is dropped too
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Count only moves when exactly one side is active
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry write, skipped on a flush edge
  always_ff @(posedge clk_i) begin
    if (push && !flush_i) begin
      mem_pc[wr_ptr_q]   <= if_pc_i;
      mem_cmpr[wr_ptr_q] <= if_cmpr_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/pc_checker.sv
`default_nettype none
`timescale 1ns/10ps

// Decode side consumer
// Forwards addresses to decode and recomputes each one independently
module pc_checker
  import pc_types_pkg::*;
  import pc_ctrl_pkg::*;
#(
  parameter pc_t BOOT_ADDR = 32'h0000_0080
) (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  // Hardening enable from the core control register
  input  wire logic           pc_hardening_i,
  // Redirect seen by the checker with its own target copy
  input  wire logic           redirect_valid_i,
  input  wire redirect_kind_e redirect_kind_i,
  input  wire pc_t            redirect_target_chk_i,
  // Glitch injection hook on the stored target copy
  input  wire pc_t            fault_chk_mask_i,
  // From the buffer
  input  wire logic           buf_valid_i,
  input  wire pc_t            buf_pc_i,
  input  wire instr_size_t    buf_cmpr_i,
  output logic                buf_ready_o,
  // Toward decode
  input  wire logic           id_ready_i,
  output logic                id_valid_o,
  output pc_t                 id_pc_o,
  // Sticky fault report
  output logic                alert_major_o,
  output redirect_kind_e      alert_kind_o
);

  chk_state_e     state_q;
  chk_state_e     state_d;

  // Last accepted address and its size
  pc_t            prev_pc_q;
  instr_size_t    prev_cmpr_q;

  // Duplicate target and its cause, captured on a redirect
  pc_t            tgt_q;
  redirect_kind_e kind_q;

  // Alert state
  logic           alert_q;
  redirect_kind_e alert_kind_q;

  // Recomputed address for the next accepted transfer
  pc_t            exp_pc;

  logic           accept;
  logic           mismatch;

  // Decode sees the buffer output directly
  assign id_valid_o  = buf_valid_i;
  assign id_pc_o     = buf_pc_i;
  assign buf_ready_o = id_ready_i;

  // Transfer into decode on this edge
  assign accept = buf_valid_i && id_ready_i;

  // Expected address by checker state
  always_comb begin
    case (state_q)
      CHK_INIT:  exp_pc = BOOT_ADDR;
      CHK_SEQ:   exp_pc = pc_incr(prev_pc_q, prev_cmpr_q);
      CHK_REDIR: exp_pc = tgt_q;
      default:   exp_pc = BOOT_ADDR;
    endcase
  end

  assign mismatch = accept && (buf_pc_i != exp_pc);

  // Next state
  // A redirect arms the target check even if an address goes through now
  always_comb begin
    state_d = state_q;
    if (redirect_valid_i) begin
      state_d = CHK_REDIR;
    end else if (accept) begin
      state_d = CHK_SEQ;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= CHK_INIT;
      alert_q      <= 1'b0;
      alert_kind_q <= REDIR_BRANCH;
    end else begin
      state_q <= state_d;
      // First failing check while hardened sets the alert for good
      if (mismatch && pc_hardening_i && !alert_q) begin
        alert_q <= 1'b1;
        // Report the redirect cause only when a target was being checked
        if (state_q == CHK_REDIR) begin
          alert_kind_q <= kind_q;
        end else begin
          alert_kind_q <= REDIR_BRANCH;
        end
      end
    end
  end

  // History of the stream
  always_ff @(posedge clk_i) begin
    if (accept) begin
      prev_pc_q   <= buf_pc_i;
      prev_cmpr_q <= buf_cmpr_i;
    end
    if (redirect_valid_i) begin
      // Mask models a glitch on the stored copy
      tgt_q  <= redirect_target_chk_i ^ fault_chk_mask_i;
      kind_q <= redirect_kind_i;
    end
  end

  assign alert_major_o = alert_q;
  assign alert_kind_o  = alert_kind_q;

endmodule

`default_nettype wire

// File: hdl/pc_harden_top.sv
`default_nettype none
`timescale 1ns/10ps

// Hardened PC subsystem
// Fetch producer, two-entry buffer and decode side checker
module pc_harden_top
  import pc_types_pkg::*;
  import pc_ctrl_pkg::*;
#(
  parameter pc_t BOOT_ADDR = 32'h0000_0080
) (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  // Fetch inputs
  input  wire instr_size_t    is_compressed_i,
  input  wire logic           redirect_valid_i,
  input  wire pc_t            redirect_target_i,
  input  wire pc_t            fault_pc_mask_i,
  // Checker inputs
  input  wire redirect_kind_e redirect_kind_i,
  input  wire pc_t            redirect_target_chk_i,
  input  wire pc_t            fault_chk_mask_i,
  input  wire logic           pc_hardening_i,
  // Decode side
  input  wire logic           id_ready_i,
  output logic                id_valid_o,
  output pc_t                 id_pc_o,
  output logic                alert_major_o,
  output redirect_kind_e      alert_kind_o
);

  // Fetch to buffer
  logic        if_valid;
  logic        if_ready;
  pc_t         if_pc;
  instr_size_t if_cmpr;
  logic        flush;

  // Buffer to checker
  logic        buf_valid;
  logic        buf_ready;
  pc_t         buf_pc;
  instr_size_t buf_cmpr;

  // Redirect empties the buffer at the same edge it moves the PC
  assign flush = redirect_valid_i;

  fetch_pc_gen #(
    .BOOT_ADDR(BOOT_ADDR)
  ) fetch_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .is_compressed_i  (is_compressed_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_target_i(redirect_target_i),
    .fault_pc_mask_i  (fault_pc_mask_i),
    .if_ready_i       (if_ready),
    .if_valid_o       (if_valid),
    .if_pc_o          (if_pc),
    .if_cmpr_o        (if_cmpr)
  );

  if_id_buffer buffer_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush),
    .if_valid_i (if_valid),
    .if_pc_i    (if_pc),
    .if_cmpr_i  (if_cmpr),
    .if_ready_o (if_ready),
    .buf_valid_o(buf_valid),
    .buf_pc_o   (buf_pc),
    .buf_cmpr_o (buf_cmpr),
    .buf_ready_i(buf_ready)
  );

  pc_checker #(
    .BOOT_ADDR(BOOT_ADDR)
  ) checker_i (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .pc_hardening_i       (pc_hardening_i),
    .redirect_valid_i     (redirect_valid_i),
    .redirect_kind_i      (redirect_kind_i),
    .redirect_target_chk_i(redirect_target_chk_i),
    .fault_chk_mask_i     (fault_chk_mask_i),
    .buf_valid_i          (buf_valid),
    .buf_pc_i             (buf_pc),
    .buf_cmpr_i           (buf_cmpr),
    .buf_ready_o          (buf_ready),
    .id_ready_i           (id_ready_i),
    .id_valid_o           (id_valid_o),
    .id_pc_o              (id_pc_o),
    .alert_major_o        (alert_major_o),
    .alert_kind_o         (alert_kind_o)
  );

endmodule

`default_nettype wire

// File: verif/pc_harden_model.svh
// Reference model of fetch, buffer and checker, stepped once per rising edge
// It reads the DUT inputs that the testbench has driven for the coming edge

// Fetch side
logic           m_valid;
pc_t            m_pc;

// Addresses between fetch and decode, oldest first
pc_t            m_q_pc[$];
instr_size_t    m_q_cmpr[$];

// Checker view of the stream
chk_state_e     m_state;
pc_t            m_prev_pc;
instr_size_t    m_prev_cmpr;
pc_t            m_tgt;
redirect_kind_e m_tgt_kind;
logic           m_alert;
redirect_kind_e m_alert_kind;

// Next address in program order, 2 for compressed and 4 otherwise
function automatic pc_t step_addr(pc_t pc, instr_size_t cmpr);
  if (cmpr) begin
    return pc + 32'd2;
  end
  return pc + 32'd4;
endfunction

task automatic model_reset();
  m_valid      = 1'b0;
  m_pc         = BOOT_ADDR;
  m_q_pc.delete();
  m_q_cmpr.delete();
  m_state      = CHK_INIT;
  m_prev_pc    = '0;
  m_prev_cmpr  = 1'b0;
  m_tgt        = '0;
  m_tgt_kind   = REDIR_BRANCH;
  m_alert      = 1'b0;
  m_alert_kind = REDIR_BRANCH;
endtask

task automatic model_edge();
  pc_t  exp;
  pc_t  sel;
  logic push;
  logic accept;
  push   = m_valid && (m_q_pc.size() < 2);
  accept = (m_q_pc.size() != 0) && id_ready_i;
  // Recompute the address that decode takes at this edge
  if (accept) begin
    case (m_state)
      CHK_INIT: exp = BOOT_ADDR;
      CHK_SEQ:  exp = step_addr(m_prev_pc, m_prev_cmpr);
      default:  exp = m_tgt;
    endcase
    if ((m_q_pc[0] != exp) && pc_hardening_i && !m_alert) begin
      m_alert      = 1'b1;
      m_alert_kind = (m_state == CHK_REDIR) ? m_tgt_kind : REDIR_BRANCH;
    end
    m_prev_pc   = m_q_pc[0];
    m_prev_cmpr = m_q_cmpr[0];
    m_state     = CHK_SEQ;
  end
  if (redirect_valid_i) begin
    // Flush drops held entries and the one on offer
    m_state    = CHK_REDIR;
    m_tgt      = redirect_target_chk_i ^ fault_chk_mask_i;
    m_tgt_kind = redirect_kind_i;
    m_q_pc.delete();
    m_q_cmpr.delete();
    sel = redirect_target_i;
  end else begin
    if (accept) begin
      void'(m_q_pc.pop_front());
      void'(m_q_cmpr.pop_front());
    end
    if (push) begin
      m_q_pc.push_back(m_pc);
      m_q_cmpr.push_back(is_compressed_i);
    end
    sel = push ? step_addr(m_pc, is_compressed_i) : m_pc;
  end
  // Glitch lands on top of the chosen next PC
  m_pc    = sel ^ fault_pc_mask_i;
  m_valid = 1'b1;
endtask

// File: verif/tb_pc_harden.sv
`default_nettype none
`timescale 1ns/10ps

// Testbench for the hardened PC subsystem
// Random fetch stream with back-pressure, redirects and injected glitches
module tb_pc_harden
  import pc_types_pkg::*;
  import pc_ctrl_pkg::*;
();

  localparam pc_t BOOT_ADDR = 32'h0000_0080;

  logic           clk_i;
  logic           rst_n_i;
  instr_size_t    is_compressed_i;
  logic           redirect_valid_i;
  pc_t            redirect_target_i;
  pc_t            fault_pc_mask_i;
  redirect_kind_e redirect_kind_i;
  pc_t            redirect_target_chk_i;
  pc_t            fault_chk_mask_i;
  logic           pc_hardening_i;
  logic           id_ready_i;
  logic           id_valid_o;
  pc_t            id_pc_o;
  logic           alert_major_o;
  redirect_kind_e alert_kind_o;

  integer         seed = 79;
  int             err_cnt;
  int             test_errs;
  int             tests_run;
  int             tests_failed;
  // Percent chance per cycle
  int             ready_pct;
  int             redir_pct;
  // One-shot glitches, applied on the next driven cycle
  pc_t            pc_glitch;
  pc_t            chk_glitch;
  redirect_kind_e glitch_kind;
  // Address the current size flag was drawn for
  pc_t            flag_pc;
  logic           flag_drawn;

  `include "pc_harden_model.svh"

  pc_harden_top #(
    .BOOT_ADDR(BOOT_ADDR)
  ) dut_i (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .is_compressed_i      (is_compressed_i),
    .redirect_valid_i     (redirect_valid_i),
    .redirect_target_i    (redirect_target_i),
    .fault_pc_mask_i      (fault_pc_mask_i),
    .redirect_kind_i      (redirect_kind_i),
    .redirect_target_chk_i(redirect_target_chk_i),
    .fault_chk_mask_i     (fault_chk_mask_i),
    .pc_hardening_i       (pc_hardening_i),
    .id_ready_i           (id_ready_i),
    .id_valid_o           (id_valid_o),
    .id_pc_o              (id_pc_o),
    .alert_major_o        (alert_major_o),
    .alert_kind_o         (alert_kind_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string sig, input pc_t got, input pc_t exp);
    $display("MISMATCH %s got %h expected %h", sig, got, exp);
    test_errs++;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    test_errs++;
  endtask

  task automatic idle_inputs();
    is_compressed_i       = 1'b0;
    redirect_valid_i      = 1'b0;
    redirect_target_i     = '0;
    fault_pc_mask_i       = '0;
    redirect_kind_i       = REDIR_BRANCH;
    redirect_target_chk_i = '0;
    fault_chk_mask_i      = '0;
    id_ready_i            = 1'b0;
  endtask

  // Called and returns at a falling edge
  task automatic apply_reset(input logic hard);
    rst_n_i = 1'b0;
    idle_inputs();
    pc_hardening_i = hard;
    flag_drawn     = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    model_reset();
  endtask

  // Drive one cycle, check decode before the edge, then step the model
  task automatic cycle_step(output logic accepted);
    logic [31:0] r;
    logic        exp_valid;
    r = $random(seed);
    // Size flag belongs to the address on offer and only changes when the PC moves
    if (!flag_drawn || (m_pc != flag_pc)) begin
      is_compressed_i = r[0];
      flag_pc         = m_pc;
      flag_drawn      = 1'b1;
    end
    id_ready_i            = ($unsigned($random(seed)) % 100) < ready_pct;
    redirect_valid_i      = ($unsigned($random(seed)) % 100) < redir_pct;
    redirect_target_i     = $random(seed) & ~32'h1;
    redirect_target_chk_i = redirect_target_i;
    r                     = $unsigned($random(seed)) % 3;
    redirect_kind_i       = redirect_kind_e'(r[1:0]);
    fault_pc_mask_i       = pc_glitch;
    fault_chk_mask_i      = chk_glitch;
    // Target glitch rides on a forced redirect
    if (chk_glitch != '0) begin
      redirect_valid_i = 1'b1;
      redirect_kind_i  = glitch_kind;
    end
    pc_glitch  = '0;
    chk_glitch = '0;
    #1;
    exp_valid = (m_q_pc.size() != 0);
    accepted  = exp_valid && id_ready_i;
    assert (id_valid_o === exp_valid)
      else report_mismatch("id_valid_o", id_valid_o, exp_valid);
    if (accepted) begin
      assert (id_pc_o === m_q_pc[0])
        else report_mismatch("id_pc_o", id_pc_o, m_q_pc[0]);
      assert (alert_major_o === m_alert)
        else report_mismatch("alert_major_o", alert_major_o, m_alert);
    end
    model_edge();
    @(negedge clk_i);
  endtask

  task automatic wait_accepts(input int n, input int max_cycles, input string name);
    int   got;
    int   cyc;
    logic acc;
    got = 0;
    cyc = 0;
    while ((got < n) && (cyc < max_cycles)) begin
      cycle_step(acc);
      if (acc) begin
        got++;
      end
      cyc++;
    end
    if (got < n) begin
      report_failure($sformatf("%s timed out after %0d cycles with %0d of %0d transfers",
                               name, cyc, got, n));
    end
  endtask

  task automatic finish_test(input string name, input logic exp_alert);
    assert (alert_major_o === exp_alert)
      else report_mismatch("alert_major_o", alert_major_o, exp_alert);
    if (exp_alert) begin
      assert (alert_kind_o === m_alert_kind)
        else report_mismatch("alert_kind_o", alert_kind_o, m_alert_kind);
    end
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    err_cnt += test_errs;
    $display("%-16s %s, %0d mismatches", name, (test_errs == 0) ? "pass" : "FAIL", test_errs);
    test_errs = 0;
  endtask

  // Single bit flip in the fetch PC register
  task automatic pc_glitch_test(input logic hard, input string name);
    apply_reset(hard);
    ready_pct = 70;
    redir_pct = 0;
    wait_accepts(8, 100, name);
    pc_glitch = 32'h1 << (($unsigned($random(seed)) % 30) + 2);
    wait_accepts(12, 150, name);
    finish_test(name, hard);
  endtask

  // Single bit flip in the checker's stored target during a redirect
  task automatic tgt_glitch_test(input logic hard, input string name);
    logic [31:0] r;
    apply_reset(hard);
    ready_pct = 70;
    redir_pct = 0;
    wait_accepts(5, 60, name);
    r           = $unsigned($random(seed)) % 3;
    glitch_kind = redirect_kind_e'(r[1:0]);
    chk_glitch  = 32'h1 << (($unsigned($random(seed)) % 30) + 2);
    wait_accepts(10, 150, name);
    if (hard) begin
      assert (alert_kind_o === glitch_kind)
        else report_mismatch("alert_kind_o", alert_kind_o, glitch_kind);
    end
    finish_test(name, hard);
  endtask

  initial begin
    err_cnt        = 0;
    test_errs      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    pc_glitch      = '0;
    chk_glitch     = '0;
    glitch_kind    = REDIR_BRANCH;
    flag_pc        = '0;
    flag_drawn     = 1'b0;
    rst_n_i        = 1'b0;
    pc_hardening_i = 1'b1;
    idle_inputs();
    @(negedge clk_i);
    // Boot address comes out first
    apply_reset(1'b1);
    assert (alert_major_o === 1'b0)
      else report_mismatch("alert_major_o", alert_major_o, 1'b0);
    ready_pct = 100;
    redir_pct = 0;
    wait_accepts(4, 20, "reset_boot");
    finish_test("reset_boot", 1'b0);
    apply_reset(1'b1);
    ready_pct = 60;
    wait_accepts(200, 1000, "sequential");
    finish_test("sequential", 1'b0);
    apply_reset(1'b1);
    redir_pct = 10;
    wait_accepts(200, 2000, "redirects");
    finish_test("redirects", 1'b0);
    pc_glitch_test(1'b1, "pc_glitch_on");
    tgt_glitch_test(1'b1, "tgt_glitch_on");
    pc_glitch_test(1'b0, "pc_glitch_off");
    tgt_glitch_test(1'b0, "tgt_glitch_off");
    $display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verif
hdl/pc_types_pkg.sv
hdl/pc_ctrl_pkg.sv
hdl/fetch_pc_gen.sv
hdl/if_id_buffer.sv
hdl/pc_checker.sv
hdl/pc_harden_top.sv
verif/tb_pc_harden.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_pc_harden -Mdir obj_dir -f verilog.f \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_pc_harden > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log || exit 1
exit 0
